// File: flappy_top.f
flappy_pkg.sv
bird_motion_fsm.sv
pipe_scroller.sv
game_referee.sv
pixel_compositor.sv
flappy_top.sv
flappy_top_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
set -e
set -o pipefail
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert --timescale 1ns/10ps \
   --top-module flappy_top_tb -f flappy_top.f -o flappy_sim
./obj_dir/flappy_sim | tee sim.log

if grep -q "sim failed" sim.log; then
   exit 1
fi

// File: flappy_top_tb.sv
`timescale 1ns/10ps
`default_nettype none

module flappy_top_tb
   import flappy_pkg::*;
();

   typedef struct packed {
      player_ctrl_t ctrl;
      logic         restart;  // pulse restart_n first
      logic         to_end;   // frames only bounds the wait for the banner
      int           frames;
      int           px;
      int           py;
      rgb565_t      exp_col;
   } test_row_t;

   localparam player_ctrl_t IDLE  = 4'b0111;
   localparam player_ctrl_t RUN   = 4'b1111;
   localparam player_ctrl_t FLAP  = 4'b1011;
   localparam player_ctrl_t LEFT  = 4'b1101;
   localparam player_ctrl_t RIGHT = 4'b1110;

   logic         vga_clk;
   logic         reset;
   logic         restart_n;
   coord_t       pix_x;
   coord_t       pix_y;
   player_ctrl_t ctrl;
   rgb565_t      pix_data;

   test_row_t   rows[$];
   string       names[$];
   int          rise_tab[8] = '{20, 16, 12, 8, 6, 4, 2, 1};
   int          mbx;     // model bird and pipes
   int          mby;
   int          mstate;  // 0..7 falling, 8..15 rising
   int          pax;
   int          pal;
   int          pbx;
   int          pbl;
   bit          mfin;
   logic [31:0] seed = 32'h3b9d_eaa7;
   int          checks;
   int          errors;
   int          row_err;

   flappy_top u_dut (
      .vga_clk   (vga_clk),
      .reset     (reset),
      .restart_n (restart_n),
      .pix_x     (pix_x),
      .pix_y     (pix_y),
      .ctrl      (ctrl),
      .pix_data  (pix_data)
   );

   always #20 vga_clk = ~vga_clk;

   function automatic logic [31:0] lcg_next(logic [31:0] s);
      return s * 32'd1664525 + 32'd1013904223;
   endfunction

   // 0 none, 1 body, 2 head
   function automatic int pipe_layer(int px, int len, int x, int y);
      int gap_top;
      int gap_bot;
      gap_top = len * 32;
      gap_bot = (len + 6) * 32;
      if (x < px || x >= px + 32)
         return 0;
      if (y < gap_top || y >= gap_bot)
         return 1;
      if (y < gap_top + 16 || y >= gap_bot - 16)
         return 2;
      return 0;
   endfunction

   function automatic bit bird_at(int x, int y);
      return x >= mbx && x < mbx + 32 && y >= mby && y < mby + 32;
   endfunction

   function automatic rgb565_t model_color(int x, int y);
      int la;
      int lb;
      la = pipe_layer(pax, pal, x, y);
      lb = pipe_layer(pbx, pbl, x, y);
      if (mfin && x >= 191 && x <= 446 && y >= 207 && y <= 270)
         return COL_BANNER;
      if (la == 1 || lb == 1)
         return COL_PIPE;
      if (la == 2 || lb == 2)
         return COL_HEAD;
      if (bird_at(x, y))
         return COL_BIRD;
      if (y >= 352)
         return COL_GROUND;
      return COL_SKY;
   endfunction

   task automatic model_reset();
      mbx    = 303;
      mby    = 223;
      mstate = 0;
      pax    = 576;
      pal    = 3;
      pbx    = 305;
      pbl    = 5;
      mfin   = 1'b0;
   endtask

   task automatic scroll_pipe(inout int x, inout int len);
      if (x > 2) begin
         x = x - 2;
      end else begin
         x   = 608;  // wrap to the right edge
         len = (len == 7) ? 2 : len + 1;
      end
   endtask

   task automatic model_step(player_ctrl_t c);
      if (c.run && !mfin) begin
         if (mstate >= 8) begin
            mby    = mby - rise_tab[mstate - 8];
            mstate = (mstate == 15) ? 0 : mstate + 1;
         end else begin
            mby    = mby + 2;
            mstate = !c.flap_n ? 8 : ((mstate == 7) ? 7 : mstate + 1);
         end
         if (!c.left_n)
            mbx = mbx - 5;
         else if (!c.right_n)
            mbx = mbx + 5;
         scroll_pipe(pax, pal);
         scroll_pipe(pbx, pbl);
         if (mby > 420 || mbx > 640)
            mfin = 1'b1;
      end
   endtask

   // colour shows at the next falling edge
   task automatic probe(int x, int y, output rgb565_t got);
      pix_x = coord_t'(x);
      pix_y = coord_t'(y);
      @(negedge vga_clk);
      got = pix_data;
      if (bird_at(x, y) &&
          (pipe_layer(pax, pal, x, y) != 0 || pipe_layer(pbx, pbl, x, y) != 0))
         mfin = 1'b1;  // collision seen by the scan
   endtask

   task automatic check_color(rgb565_t got, rgb565_t exp, int x, int y);
      checks++;
      if (got !== exp) begin
         errors++;
         row_err++;
         $display("FAIL t=%0t pix_data at (%0d,%0d): got %h, expected %h",
                  $time, x, y, got, exp);
      end
   endtask

   task automatic probe_model(int x, int y);
      rgb565_t exp;
      rgb565_t got;
      exp = model_color(x, y);
      probe(x, y, got);
      check_color(got, exp, x, y);
   endtask

   task automatic check_pos(bird_pos_t exp);
      int bx;
      int by;
      bx = int'(exp.x);
      by = int'(exp.y);
      probe_model(bx, by);  // corners just inside
      probe_model(bx + 31, by + 31);
      probe_model(bx - 1, by);
      probe_model(bx, by - 1);
      probe_model(bx + 32, by + 31);
      probe_model(bx + 31, by + 32);
   endtask

   task automatic advance_frame(player_ctrl_t c);
      ctrl  = c;
      pix_x = '0;
      pix_y = '0;
      @(negedge vga_clk);
      pix_x = 10'd1;  // off the frame start pixel
      @(negedge vga_clk);
      model_step(c);
   endtask

   task automatic wait_game_over(int limit, player_ctrl_t c);
      int      n;
      rgb565_t got;
      n   = 0;
      got = COL_SKY;
      while (got !== COL_BANNER && n < limit) begin
         advance_frame(c);
         probe(300, 240, got);
         n++;
      end
      if (got !== COL_BANNER) begin
         errors++;
         row_err++;
         $display("game over banner did not show within %0d frames", limit);
      end
   endtask

   task automatic add_row(string name, player_ctrl_t c, bit rst, bit to_end,
                          int frames, int x, int y, rgb565_t col);
      test_row_t r;
      r = '{c, rst, to_end, frames, x, y, col};
      rows.push_back(r);
      names.push_back(name);
   endtask

   task automatic load_table();
      add_row("reset bird",    IDLE,  1'b0, 1'b0, 0,   318, 238, COL_BIRD);
      add_row("reset body",    IDLE,  1'b0, 1'b0, 0,   580, 50,  COL_PIPE);
      add_row("reset head",    IDLE,  1'b0, 1'b0, 0,   580, 100, COL_HEAD);
      add_row("reset ground",  IDLE,  1'b0, 1'b0, 0,   10,  400, COL_GROUND);
      add_row("reset sky",     IDLE,  1'b0, 1'b0, 0,   10,  300, COL_SKY);
      add_row("run disabled",  IDLE,  1'b0, 1'b0, 10,  607, 50,  COL_PIPE);
      add_row("fall scroll",   RUN,   1'b0, 1'b0, 20,  536, 50,  COL_PIPE);
      add_row("pipe edge",     RUN,   1'b0, 1'b0, 0,   535, 50,  COL_SKY);
      add_row("flap",          FLAP,  1'b0, 1'b0, 1,   318, 296, COL_BIRD);
      add_row("rise 20",       RUN,   1'b0, 1'b0, 1,   318, 250, COL_BIRD);
      add_row("rise 16",       RUN,   1'b0, 1'b0, 1,   318, 240, COL_BIRD);
      add_row("rise 12",       RUN,   1'b0, 1'b0, 1,   318, 240, COL_BIRD);
      add_row("rise 8",        RUN,   1'b0, 1'b0, 1,   318, 240, COL_BIRD);
      add_row("rise 6",        RUN,   1'b0, 1'b0, 1,   318, 220, COL_BIRD);
      add_row("rise 4",        RUN,   1'b0, 1'b0, 1,   318, 220, COL_BIRD);
      add_row("rise 2",        RUN,   1'b0, 1'b0, 1,   318, 200, COL_BIRD);
      add_row("rise 1",        RUN,   1'b0, 1'b0, 1,   318, 200, COL_BIRD);
      add_row("fall again",    RUN,   1'b0, 1'b0, 1,   318, 200, COL_BIRD);
      add_row("step left",     LEFT,  1'b0, 1'b0, 4,   290, 210, COL_BIRD);
      add_row("step right",    RIGHT, 1'b0, 1'b0, 6,   320, 225, COL_BIRD);
      add_row("game end",      RUN,   1'b0, 1'b1, 150, 300, 240, COL_BANNER);
      add_row("frozen",        RUN,   1'b0, 1'b0, 5,   300, 240, COL_BANNER);
      add_row("restart head",  IDLE,  1'b1, 1'b0, 0,   580, 100, COL_HEAD);
      add_row("restart bird",  IDLE,  1'b0, 1'b0, 0,   318, 238, COL_BIRD);
   endtask

   initial begin
      #1_000_000;
      $display("run exceeded its time limit");
      $display("sim failed");
      $finish;
   end

   initial begin
      rgb565_t   got;
      bird_pos_t cur;
      int        rx;
      int        ry;
      vga_clk   = 1'b0;
      reset     = 1'b0;
      restart_n = 1'b1;
      pix_x     = '0;
      pix_y     = '0;
      ctrl      = IDLE;
      checks    = 0;
      errors    = 0;
      model_reset();
      load_table();
      repeat (2) @(negedge vga_clk);
      reset = 1'b1;
      foreach (rows[i]) begin
         row_err = 0;
         if (rows[i].restart) begin
            restart_n = 1'b0;
            @(negedge vga_clk);
            restart_n = 1'b1;
            model_reset();
         end
         if (rows[i].to_end)
            wait_game_over(rows[i].frames, rows[i].ctrl);
         else
            repeat (rows[i].frames) advance_frame(rows[i].ctrl);
         probe(rows[i].px, rows[i].py, got);
         check_color(got, rows[i].exp_col, rows[i].px, rows[i].py);
         cur.x = coord_t'(mbx);
         cur.y = coord_t'(mby);
         check_pos(cur);
         repeat (3) begin
            seed = lcg_next(seed);
            rx   = int'(seed >> 16) % 640;
            seed = lcg_next(seed);
            ry   = 1 + int'(seed >> 16) % 479;  // row 0 holds the frame start
            probe_model(rx, ry);
         end
         $display("test %0d %s: %0d errors", i, names[i], row_err);
      end
      $display("tests %0d, checks %0d, errors %0d", rows.size(), checks, errors);
      if (errors == 0)
         $display("sim passed");
      else
         $display("sim failed");
      $finish;
   end

endmodule

`default_nettype wire

// File: flappy_top.sv
`timescale 1ns/10ps
`default_nettype none

module flappy_top
   import flappy_pkg::*;
(
   input  logic         vga_clk,
   input  logic         reset,
   input  logic         restart_n,
   input  coord_t       pix_x,
   input  coord_t       pix_y,
   input  player_ctrl_t ctrl,
   output rgb565_t      pix_data
);

   logic        game_reset_n;
   logic        frame_start;
   logic        finished;
   bird_pos_t   bird;
   pipe_t       pipe_a;
   pipe_t       pipe_b;
   layer_hits_t hits;

   assign game_reset_n = reset & restart_n;  // restart acts as a full reset

   bird_motion_fsm #(
      .BIRD_X0 (10'd303),
      .BIRD_Y0 (10'd223)
   ) u_bird (
      .vga_clk     (vga_clk),
      .reset       (game_reset_n),
      .frame_start (frame_start),
      .finished    (finished),
      .ctrl        (ctrl),
      .bird        (bird)
   );

   pipe_scroller #(
      .PIPE_A_X0 (10'd576),
      .PIPE_B_X0 (10'd305)
   ) u_pipes (
      .vga_clk     (vga_clk),
      .reset       (game_reset_n),
      .frame_start (frame_start),
      .finished    (finished),
      .run         (ctrl.run),
      .pipe_a      (pipe_a),
      .pipe_b      (pipe_b)
   );

   game_referee u_referee (
      .vga_clk  (vga_clk),
      .reset    (game_reset_n),
      .bird     (bird),
      .hits     (hits),
      .finished (finished)
   );

   pixel_compositor u_pixels (
      .vga_clk     (vga_clk),
      .reset       (game_reset_n),
      .pix_x       (pix_x),
      .pix_y       (pix_y),
      .bird        (bird),
      .pipe_a      (pipe_a),
      .pipe_b      (pipe_b),
      .finished    (finished),
      .frame_start (frame_start),
      .hits        (hits),
      .pix_data    (pix_data)
   );

endmodule

`default_nettype wire

// File: pixel_compositor.sv
`timescale 1ns/10ps
`default_nettype none

module pixel_compositor
   import flappy_pkg::*;
(
   input  logic        vga_clk,
   input  logic        reset,
   input  coord_t      pix_x,
   input  coord_t      pix_y,
   input  bird_pos_t   bird,
   input  pipe_t       pipe_a,
   input  pipe_t       pipe_b,
   input  logic        finished,
   output logic        frame_start,
   output layer_hits_t hits,
   output rgb565_t     pix_data
);

   logic [1:0] hit_a;  // {body, head}
   logic [1:0] hit_b;
   logic       bird_hit;
   logic       banner_hit;
   logic       ground_hit;

   // body and head test of one pipe column at (x, y)
   function automatic logic [1:0] pipe_hit(pipe_t p, coord_t x, coord_t y);
      coord_t top_end;
      coord_t bot_start;
      logic   in_col;
      logic   body;
      logic   head;
      top_end   = coord_t'(p.len) * PIPE_UNIT;
      bot_start = (coord_t'(p.len) + GAP_UNITS) * PIPE_UNIT;
      in_col    = (x >= p.x) && (x < p.x + PIPE_W);
      body = in_col && ((y < top_end) || ((y >= bot_start) && (y < V_VALID)));
      head = in_col && (((y >= top_end) && (y < top_end + HEAD_H)) ||
                        ((y >= bot_start - HEAD_H) && (y < bot_start)));
      return {body, head};
   endfunction

   assign frame_start = (pix_x == '0) && (pix_y == '0);

   assign hit_a = pipe_hit(pipe_a, pix_x, pix_y);
   assign hit_b = pipe_hit(pipe_b, pix_x, pix_y);

   assign bird_hit = (pix_x >= bird.x) && (pix_x < bird.x + BIRD_SIZE) &&
                     (pix_y >= bird.y) && (pix_y < bird.y + BIRD_SIZE);

   assign banner_hit = (pix_x >= BANNER_X0) && (pix_x <= BANNER_X1) &&
                       (pix_y >= BANNER_Y0) && (pix_y <= BANNER_Y1);

   assign ground_hit = (pix_y >= GROUND_Y) && (pix_y < V_VALID);

   always_ff @(posedge vga_clk or negedge reset) begin
      if (!reset) begin
         hits <= '0;
      end else begin
         hits.bird      <= bird_hit;
         hits.pipe_body <= hit_a[1] || hit_b[1];
         hits.pipe_head <= hit_a[0] || hit_b[0];
         hits.ground    <= ground_hit;
         hits.banner    <= banner_hit;
         hits.collide   <= bird_hit && (|hit_a || |hit_b);  // bird over any pipe part
      end
   end

   // layer priority, banner only after game end
   always_comb begin
      if (finished && hits.banner)
         pix_data = COL_BANNER;
      else if (hits.pipe_body)
         pix_data = COL_PIPE;
      else if (hits.pipe_head)
         pix_data = COL_HEAD;
      else if (hits.bird)
         pix_data = COL_BIRD;
      else if (hits.ground)
         pix_data = COL_GROUND;
      else
         pix_data = COL_SKY;
   end

endmodule

`default_nettype wire

// File: game_referee.sv
`timescale 1ns/10ps
`default_nettype none

module game_referee
   import flappy_pkg::*;
(
   input  logic        vga_clk,
   input  logic        reset,
   input  bird_pos_t   bird,
   input  layer_hits_t hits,
   output logic        finished
);

   logic out_of_bounds;

   // x wraps past 1023 when stepping left off screen, caught here too
   assign out_of_bounds = (bird.y > FLOOR_Y) || (bird.x > H_VALID);

   always_ff @(posedge vga_clk or negedge reset) begin
      if (!reset)
         finished <= 1'b0;
      else if (hits.collide || out_of_bounds)
         finished <= 1'b1;  // sticky until restart
   end

   // game stays over until reset
   a_finish_sticky: assert property (
      @(posedge vga_clk) disable iff (!reset)
      finished |=> finished
   );

endmodule

`default_nettype wire

// File: pipe_scroller.sv
`timescale 1ns/10ps
`default_nettype none

module pipe_scroller
   import flappy_pkg::*;
#(
   parameter coord_t PIPE_A_X0 = 10'd576,
   parameter coord_t PIPE_B_X0 = 10'd305
) (
   input  logic  vga_clk,
   input  logic  reset,
   input  logic  frame_start,
   input  logic  finished,
   input  logic  run,
   output pipe_t pipe_a,
   output pipe_t pipe_b
);

   logic advance;

   // one frame step for a single pipe column
   function automatic pipe_t scroll(pipe_t p);
      pipe_t n;
      n = p;
      if (p.x > PIPE_STEP) begin
         n.x = p.x - PIPE_STEP;
      end else begin
         n.x = PIPE_WRAP_X;  // back in at the right edge
         n.len = (p.len == 3'd7) ? 3'd2 : p.len + 3'd1;
      end
      return n;
   endfunction

   assign advance = frame_start && run && !finished;

   always_ff @(posedge vga_clk or negedge reset) begin
      if (!reset) begin
         pipe_a.x   <= PIPE_A_X0;
         pipe_a.len <= 3'd3;
         pipe_b.x   <= PIPE_B_X0;
         pipe_b.len <= 3'd5;
      end else if (advance) begin
         pipe_a <= scroll(pipe_a);
         pipe_b <= scroll(pipe_b);
      end
   end

   // lengths 0 and 1 would leave no top body
   a_len_legal: assert property (
      @(posedge vga_clk) disable iff (!reset)
      (pipe_a.len inside {[3'd2:3'd7]}) && (pipe_b.len inside {[3'd2:3'd7]})
   );

endmodule

`default_nettype wire

// File: bird_motion_fsm.sv
`timescale 1ns/10ps
`default_nettype none

module bird_motion_fsm
   import flappy_pkg::*;
#(
   parameter coord_t BIRD_X0 = 10'd303,
   parameter coord_t BIRD_Y0 = 10'd223
) (
   input  logic         vga_clk,
   input  logic         reset,
   input  logic         frame_start,
   input  logic         finished,
   input  player_ctrl_t ctrl,
   output bird_pos_t    bird
);

   bird_state_e state;
   bird_state_e state_nxt;
   coord_t      x_nxt;
   coord_t      y_nxt;
   logic        advance;

   assign advance = frame_start && ctrl.run && !finished;  // once per frame

   // vertical motion
   always_comb begin
      if (state >= RISE_0) begin
         y_nxt = bird.y - coord_t'(RISE_STEP[state[2:0]]);
         if (state == RISE_7)
            state_nxt = FALL_0;
         else
            state_nxt = bird_state_e'(state + 4'd1);
      end else begin
         y_nxt = bird.y + FALL_STEP;  // falls even on the flap frame
         if (!ctrl.flap_n)
            state_nxt = RISE_0;
         else if (state == FALL_7)
            state_nxt = FALL_7;
         else
            state_nxt = bird_state_e'(state + 4'd1);
      end
   end

   // horizontal, left wins over right
   always_comb begin
      if (!ctrl.left_n)
         x_nxt = bird.x - SIDE_STEP;
      else if (!ctrl.right_n)
         x_nxt = bird.x + SIDE_STEP;
      else
         x_nxt = bird.x;
   end

   always_ff @(posedge vga_clk or negedge reset) begin
      if (!reset) begin
         state  <= FALL_0;
         bird.x <= BIRD_X0;
         bird.y <= BIRD_Y0;
      end else if (advance) begin
         state  <= state_nxt;
         bird.x <= x_nxt;
         bird.y <= y_nxt;
      end
   end

   // frame_start comes from the compositor scan decode
   a_state_on_frame: assert property (
      @(posedge vga_clk) disable iff (!reset)
      !frame_start |=> $stable(state)
   );

endmodule

`default_nettype wire

// File: flappy_pkg.sv
`default_nettype none

package flappy_pkg;

   typedef logic [9:0]  coord_t;     // scan or object coordinate
   typedef logic [15:0] rgb565_t;
   typedef logic [2:0]  pipe_len_t;  // top segment in 32 px units, 2..7

   // screen
   localparam coord_t H_VALID  = 10'd640;
   localparam coord_t V_VALID  = 10'd480;
   localparam coord_t GROUND_Y = 10'd352;
   localparam coord_t FLOOR_Y  = 10'd420;  // bird dies below this

   // sprites and motion
   localparam coord_t BIRD_SIZE   = 10'd32;
   localparam coord_t PIPE_W      = 10'd32;
   localparam coord_t PIPE_UNIT   = 10'd32;
   localparam coord_t HEAD_H      = 10'd16;
   localparam coord_t GAP_UNITS   = 10'd6;
   localparam coord_t PIPE_WRAP_X = 10'd608;
   localparam coord_t PIPE_STEP   = 10'd2;
   localparam coord_t FALL_STEP   = 10'd2;
   localparam coord_t SIDE_STEP   = 10'd5;

   // game over banner, inclusive bounds
   localparam coord_t BANNER_X0 = 10'd191;
   localparam coord_t BANNER_X1 = 10'd446;
   localparam coord_t BANNER_Y0 = 10'd207;
   localparam coord_t BANNER_Y1 = 10'd270;

   localparam rgb565_t COL_SKY    = 16'h4e19;
   localparam rgb565_t COL_GROUND = 16'hd5a8;
   localparam rgb565_t COL_BIRD   = 16'hffe0;
   localparam rgb565_t COL_PIPE   = 16'h07e0;
   localparam rgb565_t COL_HEAD   = 16'h0400;
   localparam rgb565_t COL_BANNER = 16'hf800;

   typedef enum logic [3:0] {
      FALL_0, FALL_1, FALL_2, FALL_3, FALL_4, FALL_5, FALL_6, FALL_7,
      RISE_0, RISE_1, RISE_2, RISE_3, RISE_4, RISE_5, RISE_6, RISE_7
   } bird_state_e;

   // rise amount per phase, entry 0 is the first frame after a flap
   localparam logic [7:0][4:0] RISE_STEP = {
      5'd1, 5'd2, 5'd4, 5'd6, 5'd8, 5'd12, 5'd16, 5'd20
   };

   typedef struct packed {
      logic run;      // game advancing
      logic flap_n;
      logic left_n;
      logic right_n;
   } player_ctrl_t;

   typedef struct packed {
      coord_t    x;
      pipe_len_t len;
   } pipe_t;

   typedef struct packed {
      coord_t x;
      coord_t y;
   } bird_pos_t;

   typedef struct packed {
      logic bird;
      logic pipe_body;
      logic pipe_head;
      logic ground;
      logic banner;
      logic collide;
   } layer_hits_t;

endpackage

`default_nettype wire
